//--- sim/tlb_vectors.txt
# op f0..f8 in hex, L: vaddr asid we hit paddr rights 0 0 0
# W/R/X: set way valid glb mod rwx asid tag ppn, R and X give the expected entry, F flush, T end of test f0
L FFFC5123 3C 0 1 FFF005123 7 0 0 0
L FFFFFABC 00 0 1 FFF03FABC 7 0 0 0
L 00001000 01 0 0 0 0 0 0 0
T 1 0 0 0 0 0 0 0 0
W 05 1 1 0 0 5 12 0040 0ABCDE
R 05 1 1 0 0 5 12 0040 0ABCDE
L 01005678 12 0 1 0ABCDE678 5 0 0 0
L 01005678 13 0 0 0 0 0 0 0
W 09 0 1 1 0 3 20 0100 123456
L 040090AB 77 0 1 1234560AB 3 0 0 0
W 0A 2 1 0 0 0 12 0040 00F00F
L 0100A010 12 0 0 0 0 0 0 0
T 2 0 0 0 0 0 0 0 0
L 01005678 12 0 1 0ABCDE678 5 0 0 0
L 040090AB 77 0 1 1234560AB 3 0 0 0
L FFFC5123 3C 0 1 FFF005123 7 0 0 0
L 00001000 01 0 0 0 0 0 0 0
T 3 0 0 0 0 0 0 0 0
L 01005678 12 1 1 0ABCDE678 5 0 0 0
R 05 1 1 0 1 5 12 0040 0ABCDE
X 05 1 1 0 1 5 12 0040 0ABCDE
W 05 1 1 0 0 6 12 0041 0FEDCB
R 05 1 1 0 0 6 12 0041 0FEDCB
L 01045234 12 0 1 0FEDCB234 6 0 0 0
L 01005678 12 0 0 0 0 0 0 0
T 4 0 0 0 0 0 0 0 0
F 0 0 0 0 0 0 0 0 0
L 01045234 12 0 0 0 0 0 0 0
L 040090AB 77 0 1 1234560AB 3 0 0 0
L FFFFFABC 00 0 1 FFF03FABC 7 0 0 0
R 05 1 0 0 0 6 12 0041 0FEDCB
T 5 0 0 0 0 0 0 0 0

//--- tb.f
+incdir+hdl
hdl/tlb_pkg.sv
hdl/tlb_way_ram.sv
hdl/tlb_sweep_counter.sv
hdl/tlb_ctrl_fsm.sv
hdl/tlb_lookup.sv
hdl/tlb_top.sv
sim/tlb_assert.sv
sim/tlb_checker.sv
sim/tb_tlb.sv

//--- Bender.yml
package:
  name: tlb

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/tlb_pkg.sv
      - hdl/tlb_way_ram.sv
      - hdl/tlb_sweep_counter.sv
      - hdl/tlb_ctrl_fsm.sv
      - hdl/tlb_lookup.sv
      - hdl/tlb_top.sv
  - target: simulation
    files:
      - sim/tlb_assert.sv
      - sim/tlb_checker.sv
      - sim/tb_tlb.sv

//--- sim/tb_tlb.sv
`timescale 1ns/1ps

module tb_tlb;

	localparam int WAIT_LIMIT = 1000;

	logic                clk_g;
	logic                rst_i;
	logic                xlat_i;
	logic                we_i;
	tlb_pkg::vaddr_t     vaddr_i;
	tlb_pkg::asid_t      asid_i;
	logic                result_valid_o;
	logic                hit_o;
	tlb_pkg::paddr_t     paddr_o;
	tlb_pkg::rwx_t       rights_o;
	logic                wr_i;
	logic                rd_i;
	logic                flush_i;
	tlb_pkg::set_idx_t   sw_set_i;
	tlb_pkg::way_idx_t   sw_way_i;
	tlb_pkg::tlb_entry_t sw_entry_i;
	logic                rdy_o;
	logic                rd_valid_o;
	tlb_pkg::tlb_entry_t rd_entry_o;
	logic                wb_valid_o;
	tlb_pkg::tlb_entry_t wb_entry_o;
	tlb_pkg::set_idx_t   wb_set_o;
	tlb_pkg::way_idx_t   wb_way_o;
	logic                wb_ack_i;

	// vector record, op letter and nine hex fields
	int                  fd;
	int                  code;
	logic [7:0]          op;
	logic [8*256-1:0]    line_buf;
	logic [35:0]         fld [0:8];
	// run bookkeeping
	int                  tb_errors = 0;
	int                  tests_done = 0;
	int                  err_mark = 0;
	int                  fill_cycles;
	int                  seed_val;
	bit                  expect_wb = 0;
	bit                  aborted = 0;

	tlb_top tlb_top_inst (
		.clk_g          (clk_g),
		.rst_i          (rst_i),
		.xlat_i         (xlat_i),
		.we_i           (we_i),
		.vaddr_i        (vaddr_i),
		.asid_i         (asid_i),
		.result_valid_o (result_valid_o),
		.hit_o          (hit_o),
		.paddr_o        (paddr_o),
		.rights_o       (rights_o),
		.wr_i           (wr_i),
		.rd_i           (rd_i),
		.flush_i        (flush_i),
		.sw_set_i       (sw_set_i),
		.sw_way_i       (sw_way_i),
		.sw_entry_i     (sw_entry_i),
		.rdy_o          (rdy_o),
		.rd_valid_o     (rd_valid_o),
		.rd_entry_o     (rd_entry_o),
		.wb_valid_o     (wb_valid_o),
		.wb_entry_o     (wb_entry_o),
		.wb_set_o       (wb_set_o),
		.wb_way_o       (wb_way_o),
		.wb_ack_i       (wb_ack_i)
	);

	tlb_checker checker_inst (
		.clk_g          (clk_g),
		.rst_i          (rst_i),
		.result_valid_i (result_valid_o),
		.hit_i          (hit_o),
		.paddr_i        (paddr_o),
		.rights_i       (rights_o),
		.rd_valid_i     (rd_valid_o),
		.rd_entry_i     (rd_entry_o),
		.wb_valid_i     (wb_valid_o),
		.wb_entry_i     (wb_entry_o),
		.wb_set_i       (wb_set_o),
		.wb_way_i       (wb_way_o)
	);

	// 40 ns period
	always #20 clk_g = ~clk_g;

	function automatic int total_errors();
		return tb_errors + checker_inst.error_count + tlb_top_inst.tlb_assert_inst.fail_count;
	endfunction

	// entry from fields 2 to 8 of the record
	function automatic tlb_pkg::tlb_entry_t make_entry();
		tlb_pkg::tlb_entry_t e;
		e.valid    = fld[2][0];
		e.glb      = fld[3][0];
		e.modified = fld[4][0];
		e.rwx      = fld[5][2:0];
		e.asid     = fld[6][7:0];
		e.tag      = fld[7][13:0];
		e.ppn      = fld[8][23:0];
		return e;
	endfunction

	task automatic clear_strobes();
		xlat_i  = 1'b0;
		we_i    = 1'b0;
		wr_i    = 1'b0;
		rd_i    = 1'b0;
		flush_i = 1'b0;
	endtask

	// ====================
	// waits
	// ====================
	// returns on a falling edge with rdy_o high, strobes of the last cycle cleared
	task automatic wait_ready(output int cycles);
		cycles = 0;
		while (!aborted) begin
			@(negedge clk_g);
			clear_strobes();
			cycles++;
			if (rdy_o) break;
			if (cycles >= WAIT_LIMIT) begin
				$display("timeout: rdy_o stayed low for %0d cycles", cycles);
				tb_errors++;
				aborted = 1;
			end
		end
	endtask

	// all queued lookups and reads answered
	task automatic drain_results();
		int n;
		n = 0;
		@(negedge clk_g);
		clear_strobes();
		while (!aborted && checker_inst.pending_count() != 0) begin
			@(posedge clk_g);
			n++;
			if (n >= WAIT_LIMIT) begin
				$display("timeout: %0d expected results never arrived",
					checker_inst.pending_count());
				tb_errors++;
				aborted = 1;
			end
		end
	endtask

	// wait for the victim, then acknowledge after a random delay
	task automatic ack_write_back();
		int n;
		int delay;
		n = 0;
		while (!aborted) begin
			@(negedge clk_g);
			clear_strobes();
			n++;
			if (wb_valid_o) break;
			if (n >= WAIT_LIMIT) begin
				$display("timeout: modified victim was never handed out for write-back");
				tb_errors++;
				aborted = 1;
			end
		end
		delay = $urandom_range(8, 0);
		for (int i = 0; i < delay; i++) begin
			@(negedge clk_g);
		end
		wb_ack_i = 1'b1;
		@(negedge clk_g);
		wb_ack_i = 1'b0;
	endtask

	// ====================
	// one vector record
	// ====================
	task automatic run_record();
		int n;
		case (op)
			"L": begin
				// no drain, so lookups issue back to back
				wait_ready(n);
				xlat_i  = 1'b1;
				we_i    = fld[2][0];
				vaddr_i = fld[0][31:0];
				asid_i  = fld[1][7:0];
				checker_inst.push_lookup(fld[3][0], fld[4], fld[5][2:0]);
			end
			"W": begin
				drain_results();
				wait_ready(n);
				wr_i       = 1'b1;
				sw_set_i   = fld[0][5:0];
				sw_way_i   = fld[1][1:0];
				sw_entry_i = make_entry();
				if (expect_wb) begin
					ack_write_back();
					expect_wb = 0;
				end
			end
			"R": begin
				drain_results();
				wait_ready(n);
				rd_i     = 1'b1;
				sw_set_i = fld[0][5:0];
				sw_way_i = fld[1][1:0];
				checker_inst.push_read(make_entry());
			end
			"X": begin
				// next write replaces a modified entry
				checker_inst.push_wb(make_entry(), fld[0][5:0], fld[1][1:0]);
				expect_wb = 1;
			end
			"F": begin
				drain_results();
				wait_ready(n);
				flush_i = 1'b1;
			end
			"T": begin
				drain_results();
				$display("test %0d finished with %0d errors", fld[0], total_errors() - err_mark);
				err_mark = total_errors();
				tests_done++;
			end
			default: begin
				$display("vector file has an unknown operation '%s'", op);
				tb_errors++;
			end
		endcase
	endtask

	initial begin
		seed_val = $urandom(32'h4610_dc50);
		clk_g      = 1'b0;
		rst_i      = 1'b1;
		wb_ack_i   = 1'b0;
		vaddr_i    = '0;
		asid_i     = '0;
		sw_set_i   = '0;
		sw_way_i   = '0;
		sw_entry_i = '0;
		clear_strobes();
		repeat (3) @(posedge clk_g);
		@(negedge clk_g);
		rst_i = 1'b0;

		// boot fill is one set per cycle
		wait_ready(fill_cycles);
		if (!aborted && fill_cycles != 64) begin
			$display("CHECK FAILED @ %0t: fill took %0d cycles, expected 64", $time,
				fill_cycles);
			tb_errors++;
		end

		fd = $fopen("sim/tlb_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file sim/tlb_vectors.txt");
			tb_errors++;
			aborted = 1;
		end
		while (!aborted && $fscanf(fd, "%s", op) == 1) begin
			if (op == "#") begin
				code = $fgets(line_buf, fd);
			end else begin
				code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
					fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
				// a short record would reuse stale fields
				if (code != 9) begin
					$display("vector record '%s' has %0d fields instead of 9", op, code);
					tb_errors++;
					aborted = 1;
				end else begin
					run_record();
				end
			end
		end
		if (fd != 0) $fclose(fd);

		// catch late or stray strobes
		drain_results();
		repeat (4) @(negedge clk_g);

		$display("%0d tests, %0d lookups, %0d reads, %0d write-backs checked, %0d errors",
			tests_done, checker_inst.lookups_checked, checker_inst.reads_checked,
			checker_inst.wbs_checked, total_errors());
		if (total_errors() == 0 && !aborted && tests_done > 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- sim/tlb_checker.sv
`timescale 1ns/1ps

module tlb_checker (
	input  logic                clk_g,
	input  logic                rst_i,
	input  logic                result_valid_i,
	input  logic                hit_i,
	input  tlb_pkg::paddr_t     paddr_i,
	input  tlb_pkg::rwx_t       rights_i,
	input  logic                rd_valid_i,
	input  tlb_pkg::tlb_entry_t rd_entry_i,
	input  logic                wb_valid_i,
	input  tlb_pkg::tlb_entry_t wb_entry_i,
	input  tlb_pkg::set_idx_t   wb_set_i,
	input  tlb_pkg::way_idx_t   wb_way_i
);

	// expected lookups in issue order
	bit                  exp_hit_q [$];
	tlb_pkg::paddr_t     exp_paddr_q [$];
	tlb_pkg::rwx_t       exp_rights_q [$];
	// expected software reads
	tlb_pkg::tlb_entry_t exp_rd_q [$];
	// expected write-back victims
	tlb_pkg::tlb_entry_t exp_wb_entry_q [$];
	tlb_pkg::set_idx_t   exp_wb_set_q [$];
	tlb_pkg::way_idx_t   exp_wb_way_q [$];

	int error_count = 0;
	int lookups_checked = 0;
	int reads_checked = 0;
	int wbs_checked = 0;
	// write-back already compared in this level
	bit wb_seen = 0;

	task automatic push_lookup(input bit hit, input tlb_pkg::paddr_t paddr,
			input tlb_pkg::rwx_t rights);
		exp_hit_q.push_back(hit);
		exp_paddr_q.push_back(paddr);
		exp_rights_q.push_back(rights);
	endtask

	task automatic push_read(input tlb_pkg::tlb_entry_t entry);
		exp_rd_q.push_back(entry);
	endtask

	task automatic push_wb(input tlb_pkg::tlb_entry_t entry, input tlb_pkg::set_idx_t set,
			input tlb_pkg::way_idx_t way);
		exp_wb_entry_q.push_back(entry);
		exp_wb_set_q.push_back(set);
		exp_wb_way_q.push_back(way);
	endtask

	// outstanding lookups and reads, write-backs are waited on separately
	function automatic int pending_count();
		return exp_hit_q.size() + exp_rd_q.size();
	endfunction

	// ====================
	// compares
	// ====================
	task automatic compare_lookup();
		bit              eh;
		tlb_pkg::paddr_t ep;
		tlb_pkg::rwx_t   er;
		if (exp_hit_q.size() == 0) begin
			$display("unexpected lookup result at %0t with no request pending", $time);
			error_count++;
		end else begin
			eh = exp_hit_q.pop_front();
			ep = exp_paddr_q.pop_front();
			er = exp_rights_q.pop_front();
			lookups_checked++;
			if (hit_i !== eh || paddr_i !== ep || rights_i !== er) begin
				$display("CHECK FAILED @ %0t: lookup hit %0b paddr %h rights %0d", $time,
					hit_i, paddr_i, rights_i);
				$display("    expected hit %0b paddr %h rights %0d", eh, ep, er);
				error_count++;
			end
		end
	endtask

	task automatic compare_read();
		tlb_pkg::tlb_entry_t ee;
		if (exp_rd_q.size() == 0) begin
			$display("unexpected read data at %0t with no read pending", $time);
			error_count++;
		end else begin
			ee = exp_rd_q.pop_front();
			reads_checked++;
			if (rd_entry_i !== ee) begin
				$display("CHECK FAILED @ %0t: read entry %h, expected %h", $time,
					rd_entry_i, ee);
				error_count++;
			end
		end
	endtask

	task automatic compare_write_back();
		tlb_pkg::tlb_entry_t ee;
		tlb_pkg::set_idx_t   es;
		tlb_pkg::way_idx_t   ew;
		if (exp_wb_entry_q.size() == 0) begin
			$display("unexpected write-back at %0t for an entry that was not modified", $time);
			error_count++;
		end else begin
			ee = exp_wb_entry_q.pop_front();
			es = exp_wb_set_q.pop_front();
			ew = exp_wb_way_q.pop_front();
			wbs_checked++;
			if (wb_entry_i !== ee || wb_set_i !== es || wb_way_i !== ew) begin
				$display("CHECK FAILED @ %0t: write-back %h set %0d way %0d", $time,
					wb_entry_i, wb_set_i, wb_way_i);
				$display("    expected %h set %0d way %0d", ee, es, ew);
				error_count++;
			end
		end
	endtask

	// outputs settle after the rising edge, sample on the falling one
	always @(negedge clk_g) begin
		if (!rst_i) begin
			if (result_valid_i) compare_lookup();
			if (rd_valid_i) compare_read();
			// one compare per write-back level
			if (wb_valid_i && !wb_seen) compare_write_back();
		end
		wb_seen = wb_valid_i;
	end

endmodule

//--- sim/tlb_assert.sv
`timescale 1ns/1ps

module tlb_assert (
	input  logic                clk_g,
	input  logic                rst_i,
	input  logic                xlat_i,
	input  logic                rdy_i,
	input  logic                result_valid_i,
	input  logic                rd_valid_i,
	input  logic                wb_valid_i,
	input  tlb_pkg::tlb_entry_t wb_entry_i,
	input  logic                wb_ack_i
);

	// failures seen so far, read by the testbench
	int fail_count = 0;

	// ====================
	// write-back protocol
	// ====================
	// level and payload held until the acknowledge
	assert property (@(posedge clk_g) disable iff (rst_i)
		wb_valid_i && !wb_ack_i |=> wb_valid_i && $stable(wb_entry_i))
	else begin
		$error("write-back dropped or changed before acknowledge");
		fail_count++;
	end

	// table is busy while a victim is out
	assert property (@(posedge clk_g) disable iff (rst_i) wb_valid_i |-> !rdy_i)
	else begin
		$error("rdy high during write-back");
		fail_count++;
	end

	// accepted lookup answers two cycles later
	assert property (@(posedge clk_g) disable iff (rst_i)
		xlat_i && rdy_i |-> ##2 result_valid_i)
	else begin
		$error("lookup result not two cycles after request");
		fail_count++;
	end

	// quiet outputs while reset is held
	assert property (@(posedge clk_g)
		rst_i |-> !result_valid_i && !rd_valid_i && !wb_valid_i && !rdy_i)
	else begin
		$error("output strobe high during reset");
		fail_count++;
	end

endmodule

bind tlb_top tlb_assert tlb_assert_inst (
	.clk_g          (clk_g),
	.rst_i          (rst_i),
	.xlat_i         (xlat_i),
	.rdy_i          (rdy_o),
	.result_valid_i (result_valid_o),
	.rd_valid_i     (rd_valid_o),
	.wb_valid_i     (wb_valid_o),
	.wb_entry_i     (wb_entry_o),
	.wb_ack_i       (wb_ack_i)
);

//--- hdl/tlb_top.sv
`timescale 1ns/1ps
`include "tlb_cfg.svh"

module tlb_top (
	input  logic                 clk_g,
	input  logic                 rst_i,
	// translation
	input  logic                 xlat_i,
	input  logic                 we_i,
	input  tlb_pkg::vaddr_t      vaddr_i,
	input  tlb_pkg::asid_t       asid_i,
	output logic                 result_valid_o,
	output logic                 hit_o,
	output tlb_pkg::paddr_t      paddr_o,
	output tlb_pkg::rwx_t        rights_o,
	// software entry access
	input  logic                 wr_i,
	input  logic                 rd_i,
	input  logic                 flush_i,
	input  tlb_pkg::set_idx_t    sw_set_i,
	input  tlb_pkg::way_idx_t    sw_way_i,
	input  tlb_pkg::tlb_entry_t  sw_entry_i,
	output logic                 rdy_o,
	output logic                 rd_valid_o,
	output tlb_pkg::tlb_entry_t  rd_entry_o,
	// write-back
	output logic                 wb_valid_o,
	output tlb_pkg::tlb_entry_t  wb_entry_o,
	output tlb_pkg::set_idx_t    wb_set_o,
	output tlb_pkg::way_idx_t    wb_way_o,
	input  logic                 wb_ack_i
);

	// admin port bus
	tlb_pkg::set_idx_t                     ram_addr;
	logic [`TLB_WAYS-1:0]                  ram_we;
	tlb_pkg::tlb_entry_t [`TLB_WAYS-1:0]   ram_wdata;
	tlb_pkg::tlb_entry_t [`TLB_WAYS-1:0]   ram_rdata;
	// lookup port bus
	tlb_pkg::set_idx_t                     upd_set;
	logic [`TLB_WAYS-1:0]                  upd_we;
	tlb_pkg::tlb_entry_t                   upd_data;
	tlb_pkg::tlb_entry_t [`TLB_WAYS-1:0]   way_data;
	// sweep
	tlb_pkg::set_idx_t                     sweep_set;
	logic                                  sweep_last;
	logic                                  sweep_clear;
	logic                                  sweep_step;
	logic                                  xlat_ok;

	// lookups only while the table is idle
	assign xlat_ok = xlat_i & rdy_o;

	// ====================
	// ways
	// ====================
	for (genvar w = 0; w < `TLB_WAYS; w++) begin : g_way
		tlb_way_ram way_inst (
			.clk_g    (clk_g),
			.a_addr_i (ram_addr),
			.a_we_i   (ram_we[w]),
			.a_data_i (ram_wdata[w]),
			.a_data_o (ram_rdata[w]),
			.b_addr_i (upd_set),
			.b_we_i   (upd_we[w]),
			.b_data_i (upd_data),
			.b_data_o (way_data[w])
		);
	end

	tlb_sweep_counter sweep_inst (
		.clk_g   (clk_g),
		.rst_i   (rst_i),
		.clear_i (sweep_clear),
		.step_i  (sweep_step),
		.set_o   (sweep_set),
		.last_o  (sweep_last)
	);

	tlb_ctrl_fsm ctrl_inst (
		.clk_g         (clk_g),
		.rst_i         (rst_i),
		.wr_i          (wr_i),
		.rd_i          (rd_i),
		.flush_i       (flush_i),
		.sw_set_i      (sw_set_i),
		.sw_way_i      (sw_way_i),
		.sw_entry_i    (sw_entry_i),
		.rdy_o         (rdy_o),
		.rd_valid_o    (rd_valid_o),
		.rd_entry_o    (rd_entry_o),
		.wb_valid_o    (wb_valid_o),
		.wb_entry_o    (wb_entry_o),
		.wb_set_o      (wb_set_o),
		.wb_way_o      (wb_way_o),
		.wb_ack_i      (wb_ack_i),
		.sweep_set_i   (sweep_set),
		.sweep_last_i  (sweep_last),
		.sweep_clear_o (sweep_clear),
		.sweep_step_o  (sweep_step),
		.ram_addr_o    (ram_addr),
		.ram_we_o      (ram_we),
		.ram_wdata_o   (ram_wdata),
		.ram_rdata_i   (ram_rdata)
	);

	tlb_lookup lookup_inst (
		.clk_g          (clk_g),
		.rst_i          (rst_i),
		.xlat_i         (xlat_ok),
		.we_i           (we_i),
		.vaddr_i        (vaddr_i),
		.asid_i         (asid_i),
		.way_data_i     (way_data),
		.upd_set_o      (upd_set),
		.upd_we_o       (upd_we),
		.upd_data_o     (upd_data),
		.result_valid_o (result_valid_o),
		.hit_o          (hit_o),
		.paddr_o        (paddr_o),
		.rights_o       (rights_o)
	);

endmodule

//--- hdl/tlb_lookup.sv
`timescale 1ns/1ps
`include "tlb_cfg.svh"

module tlb_lookup (
	input  logic                                  clk_g,
	input  logic                                  rst_i,
	// request, already gated by ready
	input  logic                                  xlat_i,
	input  logic                                  we_i,
	input  tlb_pkg::vaddr_t                       vaddr_i,
	input  tlb_pkg::asid_t                        asid_i,
	// lookup port read data, one cycle behind vaddr_i
	input  tlb_pkg::tlb_entry_t [`TLB_WAYS-1:0]   way_data_i,
	// lookup port address and modified-bit update
	output tlb_pkg::set_idx_t                     upd_set_o,
	output logic [`TLB_WAYS-1:0]                  upd_we_o,
	output tlb_pkg::tlb_entry_t                   upd_data_o,
	// result, two cycles after the request
	output logic                                  result_valid_o,
	output logic                                  hit_o,
	output tlb_pkg::paddr_t                       paddr_o,
	output tlb_pkg::rwx_t                         rights_o
);

	// stage 1, aligned with the ram read
	logic                  xlat_q;
	logic                  we_q;
	tlb_pkg::vaddr_t       vaddr_q;
	tlb_pkg::asid_t        asid_q;
	// compare results
	logic                  hit_any;
	tlb_pkg::way_idx_t     hit_way;
	tlb_pkg::tlb_entry_t   hit_entry;
	tlb_pkg::set_idx_t     upd_set_q;

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			xlat_q <= 1'b0;
			we_q   <= 1'b0;
		end else begin
			xlat_q <= xlat_i;
			we_q   <= we_i;
		end
	end

	always_ff @(posedge clk_g) begin
		vaddr_q <= vaddr_i;
		asid_q  <= asid_i;
	end

	// ====================
	// way compare
	// ====================
	always_comb begin
		hit_any   = 1'b0;
		hit_way   = '0;
		hit_entry = way_data_i[0];
		// walk down so the lowest matching way is the one kept
		for (int w = `TLB_WAYS-1; w >= 0; w--) begin
			if (way_data_i[w].valid
				&& way_data_i[w].tag == vaddr_q[`TLB_VADDR_BITS-1 -: `TLB_TAG_BITS]
				&& (way_data_i[w].asid == asid_q || way_data_i[w].glb)
				&& |way_data_i[w].rwx) begin
				hit_any   = 1'b1;
				hit_way   = tlb_pkg::way_idx_t'(w);
				hit_entry = way_data_i[w];
			end
		end
	end

	// stage 2 result and store-hit update strobe
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			result_valid_o <= 1'b0;
			hit_o          <= 1'b0;
			upd_we_o       <= '0;
		end else begin
			result_valid_o <= xlat_q;
			hit_o          <= xlat_q & hit_any;
			upd_we_o       <= '0;
			if (xlat_q && we_q && hit_any) upd_we_o[hit_way] <= 1'b1;
		end
	end

	always_ff @(posedge clk_g) begin
		// a miss reports zero address and no rights
		paddr_o    <= hit_any ? {hit_entry.ppn, vaddr_q[`TLB_PAGE_BITS-1:0]} : '0;
		rights_o   <= hit_any ? hit_entry.rwx : '0;
		upd_set_q  <= vaddr_q[`TLB_PAGE_BITS +: `TLB_SETS_LOG2];
		upd_data_o <= hit_entry;
		upd_data_o.modified <= 1'b1;
	end

	// pending update owns the port, a lookup in that cycle reads the updated set
	assign upd_set_o = |upd_we_o ? upd_set_q : vaddr_i[`TLB_PAGE_BITS +: `TLB_SETS_LOG2];

endmodule

//--- hdl/tlb_ctrl_fsm.sv
`timescale 1ns/1ps
`include "tlb_cfg.svh"

module tlb_ctrl_fsm (
	input  logic                                  clk_g,
	input  logic                                  rst_i,
	// software commands, single-cycle strobes
	input  logic                                  wr_i,
	input  logic                                  rd_i,
	input  logic                                  flush_i,
	input  tlb_pkg::set_idx_t                     sw_set_i,
	input  tlb_pkg::way_idx_t                     sw_way_i,
	input  tlb_pkg::tlb_entry_t                   sw_entry_i,
	output logic                                  rdy_o,
	output logic                                  rd_valid_o,
	output tlb_pkg::tlb_entry_t                   rd_entry_o,
	// write-back of a modified victim
	output logic                                  wb_valid_o,
	output tlb_pkg::tlb_entry_t                   wb_entry_o,
	output tlb_pkg::set_idx_t                     wb_set_o,
	output tlb_pkg::way_idx_t                     wb_way_o,
	input  logic                                  wb_ack_i,
	// sweep counter
	input  tlb_pkg::set_idx_t                     sweep_set_i,
	input  logic                                  sweep_last_i,
	output logic                                  sweep_clear_o,
	output logic                                  sweep_step_o,
	// admin port of every way
	output tlb_pkg::set_idx_t                     ram_addr_o,
	output logic [`TLB_WAYS-1:0]                  ram_we_o,
	output tlb_pkg::tlb_entry_t [`TLB_WAYS-1:0]   ram_wdata_o,
	input  tlb_pkg::tlb_entry_t [`TLB_WAYS-1:0]   ram_rdata_i
);

	tlb_pkg::tlb_state_t state;
	// command captured in run
	tlb_pkg::set_idx_t   set_q;
	tlb_pkg::way_idx_t   way_q;
	tlb_pkg::tlb_entry_t entry_q;
	// entry about to be replaced
	tlb_pkg::tlb_entry_t victim_q;
	tlb_pkg::tlb_entry_t boot_entry;

	// commands are only taken in run
	assign rdy_o = (state == tlb_pkg::ST_RUN);

	// boot mapping for the set being filled
	always_comb begin
		boot_entry          = '0;
		boot_entry.valid    = 1'b1;
		boot_entry.glb      = 1'b1;
		boot_entry.rwx      = 3'd7;
		boot_entry.tag      = `TLB_BOOT_TAG;
		boot_entry.ppn      = `TLB_BOOT_PPN_BASE + tlb_pkg::ppn_t'(sweep_set_i);
	end

	// ====================
	// admin port drive
	// ====================
	always_comb begin
		ram_addr_o    = set_q;
		ram_we_o      = '0;
		ram_wdata_o   = '0;
		sweep_clear_o = 1'b0;
		sweep_step_o  = 1'b0;
		case (state)
			tlb_pkg::ST_FILL: begin
				// last way gets the boot page, the others stay invalid
				ram_addr_o                = sweep_set_i;
				ram_we_o                  = '1;
				ram_wdata_o[`TLB_WAYS-1]  = boot_entry;
				sweep_step_o              = 1'b1;
			end
			tlb_pkg::ST_RUN: begin
				// read ahead for rd and wr, data lands next cycle
				ram_addr_o    = sw_set_i;
				sweep_clear_o = flush_i;
			end
			tlb_pkg::ST_FLUSH_RD: begin
				ram_addr_o = sweep_set_i;
			end
			tlb_pkg::ST_FLUSH_WR: begin
				ram_addr_o   = sweep_set_i;
				ram_we_o     = '1;
				sweep_step_o = 1'b1;
				// global entries survive the flush
				for (int w = 0; w < `TLB_WAYS; w++) begin
					ram_wdata_o[w]       = ram_rdata_i[w];
					ram_wdata_o[w].valid = ram_rdata_i[w].valid & ram_rdata_i[w].glb;
				end
			end
			tlb_pkg::ST_WR: begin
				ram_we_o[way_q] = 1'b1;
				ram_wdata_o     = {`TLB_WAYS{entry_q}};
			end
			default: begin
				ram_addr_o = set_q;
			end
		endcase
	end

	// ====================
	// state and strobes
	// ====================
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			state      <= tlb_pkg::ST_FILL;
			rd_valid_o <= 1'b0;
			wb_valid_o <= 1'b0;
		end else begin
			rd_valid_o <= 1'b0;
			case (state)
				tlb_pkg::ST_FILL: begin
					if (sweep_last_i) state <= tlb_pkg::ST_RUN;
				end
				tlb_pkg::ST_RUN: begin
					// flush first, then write, then read
					if (flush_i) state <= tlb_pkg::ST_FLUSH_RD;
					else if (wr_i) state <= tlb_pkg::ST_WR_RD;
					else if (rd_i) state <= tlb_pkg::ST_RD;
				end
				tlb_pkg::ST_FLUSH_RD: state <= tlb_pkg::ST_FLUSH_WR;
				tlb_pkg::ST_FLUSH_WR: begin
					state <= sweep_last_i ? tlb_pkg::ST_RUN : tlb_pkg::ST_FLUSH_RD;
				end
				tlb_pkg::ST_RD: begin
					rd_valid_o <= 1'b1;
					state      <= tlb_pkg::ST_RUN;
				end
				tlb_pkg::ST_WR_RD: state <= tlb_pkg::ST_WR_CHK;
				tlb_pkg::ST_WR_CHK: begin
					// dirty victim must reach the page table first
					if (victim_q.valid && victim_q.modified) begin
						wb_valid_o <= 1'b1;
						state      <= tlb_pkg::ST_WB;
					end else begin
						state <= tlb_pkg::ST_WR;
					end
				end
				tlb_pkg::ST_WB: begin
					if (wb_ack_i) begin
						wb_valid_o <= 1'b0;
						state      <= tlb_pkg::ST_WR;
					end
				end
				tlb_pkg::ST_WR: state <= tlb_pkg::ST_RUN;
				default: state <= tlb_pkg::ST_RUN;
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clk_g) begin
		if (state == tlb_pkg::ST_RUN) begin
			set_q   <= sw_set_i;
			way_q   <= sw_way_i;
			entry_q <= sw_entry_i;
		end
		if (state == tlb_pkg::ST_RD) rd_entry_o <= ram_rdata_i[way_q];
		if (state == tlb_pkg::ST_WR_RD) victim_q <= ram_rdata_i[way_q];
		// held stable for the whole write-back
		if (state == tlb_pkg::ST_WR_CHK) begin
			wb_entry_o <= victim_q;
			wb_set_o   <= set_q;
			wb_way_o   <= way_q;
		end
	end

endmodule

//--- hdl/tlb_sweep_counter.sv
`timescale 1ns/1ps

module tlb_sweep_counter (
	input  logic              clk_g,
	input  logic              rst_i,
	// restart the sweep at set 0
	input  logic              clear_i,
	// move to the next set
	input  logic              step_i,
	output tlb_pkg::set_idx_t set_o,
	// high while the last set is addressed
	output logic              last_o
);

	// ====================
	// set index
	// ====================
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			set_o <= '0;
		end else if (clear_i) begin
			set_o <= '0;
		end else if (step_i) begin
			// wraps back to 0 after the last set
			set_o <= set_o + 1'b1;
		end
	end

	// all ones is the final set of the table
	assign last_o = (set_o == '1);

endmodule

//--- hdl/tlb_way_ram.sv
`timescale 1ns/1ps
`include "tlb_cfg.svh"

module tlb_way_ram (
	input  logic                 clk_g,
	// admin port, owned by the control fsm
	input  tlb_pkg::set_idx_t    a_addr_i,
	input  logic                 a_we_i,
	input  tlb_pkg::tlb_entry_t  a_data_i,
	output tlb_pkg::tlb_entry_t  a_data_o,
	// lookup port, read by translation and written by modified-bit updates
	input  tlb_pkg::set_idx_t    b_addr_i,
	input  logic                 b_we_i,
	input  tlb_pkg::tlb_entry_t  b_data_i,
	output tlb_pkg::tlb_entry_t  b_data_o
);

	// one entry per set
	tlb_pkg::tlb_entry_t mem [0:`TLB_SETS-1];

	// both ports read-first, data out one cycle after the address
	always_ff @(posedge clk_g) begin
		if (a_we_i) begin
			mem[a_addr_i] <= a_data_i;
		end
		// same-address writes on both ports let port b win
		if (b_we_i) begin
			mem[b_addr_i] <= b_data_i;
		end
		a_data_o <= mem[a_addr_i];
		b_data_o <= mem[b_addr_i];
	end

endmodule

//--- hdl/tlb_pkg.sv
`include "tlb_cfg.svh"

package tlb_pkg;

	// ====================
	// width types
	// ====================
	typedef logic [`TLB_VADDR_BITS-1:0] vaddr_t;
	typedef logic [`TLB_PADDR_BITS-1:0] paddr_t;
	typedef logic [`TLB_ASID_BITS-1:0] asid_t;
	typedef logic [`TLB_SETS_LOG2-1:0] set_idx_t;
	typedef logic [$clog2(`TLB_WAYS)-1:0] way_idx_t;
	typedef logic [`TLB_TAG_BITS-1:0] tag_t;
	typedef logic [`TLB_PPN_BITS-1:0] ppn_t;
	// read, write, execute
	typedef logic [2:0] rwx_t;

	// one stored translation, 52 bits
	typedef struct packed {
		logic valid;
		// global entries ignore the asid compare
		logic glb;
		// set by a store hit, drives write-back on replace
		logic modified;
		rwx_t rwx;
		asid_t asid;
		tag_t tag;
		ppn_t ppn;
	} tlb_entry_t;

	// control fsm states
	typedef enum logic [3:0] {
		ST_FILL, ST_RUN, ST_FLUSH_RD, ST_FLUSH_WR, ST_RD,
		ST_WR_RD, ST_WR_CHK, ST_WB, ST_WR
	} tlb_state_t;

endpackage

//--- hdl/tlb_cfg.svh
`ifndef TLB_CFG_SVH
`define TLB_CFG_SVH

// ====================
// tlb geometry
// ====================
`define TLB_WAYS          4
`define TLB_SETS_LOG2     6
`define TLB_SETS          (1 << `TLB_SETS_LOG2)
`define TLB_PAGE_BITS     12

// address and field widths
`define TLB_VADDR_BITS    32
`define TLB_PADDR_BITS    36
`define TLB_ASID_BITS     8
`define TLB_PPN_BITS      24
// tag is what is left above set index and page offset
`define TLB_TAG_BITS      (`TLB_VADDR_BITS - `TLB_SETS_LOG2 - `TLB_PAGE_BITS)

// boot region sits at the very top of virtual space
`define TLB_BOOT_TAG      14'h3FFF
`define TLB_BOOT_PPN_BASE 24'hFFF000

`endif
